//--- verilog/routerPkg.sv
`default_nettype none

package routerPkg;

  localparam int numPorts = 5;

  // Port numbering, also the order of the priority rotation
  typedef enum logic [2:0] {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast  = 3'd2,
    portWest  = 3'd3,
    portSouth = 3'd4
  } portIdx;

  // Flit identifier carried next to every flit word
  typedef enum logic [2:0] {
    kindIdle   = 3'd0,
    kindHeader = 3'd1,
    kindBody   = 3'd2,
    kindTail   = 3'd3
  } flitKind;

  typedef logic [11:0] pktLen;

  typedef struct packed {
    logic [3:0] dest;
    pktLen      len;
  } headerView;

  // A header flit carries destination and packet length, other flits carry raw payload
  typedef union packed {
    headerView   header;
    logic [15:0] payload;
  } flitWord;

  // One-hot output grant, all zero when the output is idle
  typedef logic [numPorts-1:0] grantVec;

endpackage

`default_nettype wire

//--- verilog/allocBus.sv
`default_nettype none

interface allocBus
  import routerPkg::*;
();

  logic [numPorts-1:0] req;
  flitKind             kind [numPorts];
  flitWord             word [numPorts];
  grantVec             grant;

  modport arb (
    input  req,
    input  kind,
    input  word,
    output grant
  );

  // The switch only needs the flits and who owns the output
  modport sw (
    input  kind,
    input  word,
    input  grant
  );

endinterface

`default_nettype wire

//--- verilog/holdTimer.sv
`default_nettype none

module holdTimer
  import routerPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  flitKind kind,
  input  flitWord word,
  input  logic    run,
  output logic    timesUp
);

  pktLen holdLen;
  pktLen count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdLen <= '0;
      count   <= '0;
    end
    else
    begin
      // Any header on this port sets the length, granted or not
      if (kind == kindHeader)
      begin
        holdLen <= word.header.len;
      end
      if (run)
      begin
        count <= count + 12'd1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  assign timesUp = (count == holdLen);

  // The arbiter stops the count at the stored length, so it can never run past it
  assert property (@(posedge clk) disable iff (rst) run |-> (count <= holdLen))
    else $error("holdTimer: count %0h ran past length %0h", count, holdLen);

endmodule

`default_nettype wire

//--- verilog/portArbiter.sv
`default_nettype none

module portArbiter
  import routerPkg::*;
(
  input  logic clk,
  input  logic rst,
  allocBus.arb bus
);

  grantVec             grantQ;
  grantVec             nextGrant;
  logic [numPorts-1:0] run;
  logic [numPorts-1:0] timesUp;
  portIdx              owner;

  for (genvar p = 0; p < numPorts; p++)
  begin : genTimer
    holdTimer timer_i (
      .clk     (clk),
      .rst     (rst),
      .kind    (bus.kind[p]),
      .word    (bus.word[p]),
      .run     (run[p]),
      .timesUp (timesUp[p])
    );
  end

  // Return the first requester found when scanning from start in rotation order
  function automatic grantVec pickNext(logic [numPorts-1:0] req, int start);
    grantVec pick;
    int      idx;
    pick = '0;
    // Scanning backwards lets the earliest port in rotation overwrite later ones
    for (int i = numPorts - 1; i >= 0; i--)
    begin
      idx = (start + i) % numPorts;
      if (req[idx])
      begin
        pick = '0;
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  // Index of the current owner, only meaningful while grantQ is non-zero
  always_comb
  begin
    owner = portLocal;
    for (int p = 0; p < numPorts; p++)
    begin
      if (grantQ[p])
      begin
        owner = portIdx'(p);
      end
    end
  end

  always_comb
  begin
    run = '0;
    if (grantQ == '0)
    begin
      // Fixed priority from idle
      nextGrant = pickNext(bus.req, int'(portLocal));
    end
    else if (bus.req[owner] && !timesUp[owner])
    begin
      run[owner] = 1'b1;
      nextGrant  = grantQ;
    end
    else
    begin
      // Start with the port after the owner, the owner itself comes last
      nextGrant = pickNext(bus.req, (int'(owner) + 1) % numPorts);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grantQ <= '0;
    end
    else
    begin
      grantQ <= nextGrant;
    end
  end

  assign bus.grant = grantQ;

  assert property (@(posedge clk) disable iff (rst) $onehot0(bus.grant))
    else $error("portArbiter: grant %0h is not one-hot", bus.grant);

  // A newly set grant bit must come from a request seen in the previous cycle
  assert property (@(posedge clk) disable iff (rst)
    ((bus.grant & ~$past(bus.grant) & ~$past(bus.req)) == '0))
    else $error("portArbiter: grant %0h rose without a request", bus.grant);

endmodule

`default_nettype wire

//--- verilog/flitSwitch.sv
`default_nettype none

module flitSwitch
  import routerPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  allocBus.sw     bus,
  output logic    outValid,
  output flitKind outKind,
  output flitWord outWord
);

  flitKind selKind;
  flitWord selWord;

  // Grant is one-hot or zero, so at most one port is picked
  always_comb
  begin
    selKind = kindIdle;
    selWord = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      if (bus.grant[p])
      begin
        selKind = bus.kind[p];
        selWord = bus.word[p];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= (selKind != kindIdle);
    end
  end

  always_ff @(posedge clk)
  begin
    outKind <= selKind;
    outWord <= selWord;
  end

  // An idle output in one cycle means nothing valid in the next
  assert property (@(posedge clk) disable iff (rst) (bus.grant == '0) |=> !outValid)
    else $error("flitSwitch: outValid high after an idle grant");

endmodule

`default_nettype wire

//--- verilog/outputPortTop.sv
`default_nettype none

module outputPortTop
  import routerPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    reqL,
  input  logic    reqN,
  input  logic    reqE,
  input  logic    reqW,
  input  logic    reqS,
  input  flitKind kindL,
  input  flitKind kindN,
  input  flitKind kindE,
  input  flitKind kindW,
  input  flitKind kindS,
  input  flitWord wordL,
  input  flitWord wordN,
  input  flitWord wordE,
  input  flitWord wordW,
  input  flitWord wordS,
  output grantVec grant,
  output logic    outValid,
  output flitKind outKind,
  output flitWord outWord
);

  allocBus bus_i ();

  assign bus_i.req[portLocal]  = reqL;
  assign bus_i.req[portNorth]  = reqN;
  assign bus_i.req[portEast]   = reqE;
  assign bus_i.req[portWest]   = reqW;
  assign bus_i.req[portSouth]  = reqS;

  assign bus_i.kind[portLocal] = kindL;
  assign bus_i.kind[portNorth] = kindN;
  assign bus_i.kind[portEast]  = kindE;
  assign bus_i.kind[portWest]  = kindW;
  assign bus_i.kind[portSouth] = kindS;

  assign bus_i.word[portLocal] = wordL;
  assign bus_i.word[portNorth] = wordN;
  assign bus_i.word[portEast]  = wordE;
  assign bus_i.word[portWest]  = wordW;
  assign bus_i.word[portSouth] = wordS;

  assign grant = bus_i.grant;

  portArbiter arb_i (
    .clk (clk),
    .rst (rst),
    .bus (bus_i.arb)
  );

  flitSwitch switch_i (
    .clk      (clk),
    .rst      (rst),
    .bus      (bus_i.sw),
    .outValid (outValid),
    .outKind  (outKind),
    .outWord  (outWord)
  );

endmodule

`default_nettype wire

//--- verif/outputPortTb.sv
`default_nettype none

module outputPortTb
  import routerPkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  logic                clk;
  logic                rst;
  logic [numPorts-1:0] req;
  flitKind             kind [numPorts];
  flitWord             word [numPorts];
  grantVec             grant;
  logic                outValid;
  flitKind             outKind;
  flitWord             outWord;
  grantVec             curGrant;
  int                  errors;
  int                  checks;

  outputPortTop dut_i (
    .clk (clk), .rst (rst),
    .reqL (req[portLocal]), .reqN (req[portNorth]), .reqE (req[portEast]),
    .reqW (req[portWest]), .reqS (req[portSouth]),
    .kindL (kind[portLocal]), .kindN (kind[portNorth]), .kindE (kind[portEast]),
    .kindW (kind[portWest]), .kindS (kind[portSouth]),
    .wordL (word[portLocal]), .wordN (word[portNorth]), .wordE (word[portEast]),
    .wordW (word[portWest]), .wordS (word[portSouth]),
    .grant (grant), .outValid (outValid), .outKind (outKind), .outWord (outWord)
  );

  always #4 clk = ~clk;

  function automatic grantVec oneHot(int p);
    grantVec g;
    g = '0;
    g[p] = 1'b1;
    return g;
  endfunction

  // First requester after port "after" in the order L N E W S, ending with "after" itself
  function automatic grantVec rotationWinner(logic [numPorts-1:0] reqs, int after);
    int p;
    for (int i = 1; i <= numPorts; i++)
    begin
      p = (after + i) % numPorts;
      if (reqs[p])
        return oneHot(p);
    end
    return '0;
  endfunction

  task automatic checkGrant(input grantVec exp);
    checks++;
    if (grant !== exp)
    begin
      errors++;
      $display("CHECK FAILED grant expected %h got %h at %0t", exp, grant, $time);
    end
  endtask

  task automatic checkValid(input logic exp);
    checks++;
    if (outValid !== exp)
    begin
      errors++;
      $display("CHECK FAILED outValid expected %h got %h at %0t", exp, outValid, $time);
    end
  endtask

  task automatic checkFlit(input flitKind expKind, input flitWord expWord);
    checks++;
    if (outKind !== expKind)
    begin
      errors++;
      $display("CHECK FAILED outKind expected %h got %h at %0t", expKind, outKind, $time);
    end
    if (outWord !== expWord)
    begin
      errors++;
      $display("CHECK FAILED outWord expected %h got %h at %0t", expWord, outWord, $time);
    end
  endtask

  task automatic sendHeader(input int p, input int len);
    req[p] = 1'b1;
    kind[p] = kindHeader;
    word[p].header.dest = 4'($urandom);
    word[p].header.len = pktLen'(len);
  endtask

  // Requesting ports send body flits and the rest go idle
  task automatic driveBodies(input logic [numPorts-1:0] reqs);
    req = reqs;
    for (int p = 0; p < numPorts; p++)
    begin
      kind[p] = reqs[p] ? kindBody : kindIdle;
      word[p].payload = reqs[p] ? 16'($urandom) : 16'h0;
    end
  endtask

  // Advance one clock and expect the output to show what the granted port drove before it
  task automatic step(input grantVec exp);
    flitKind expKind;
    flitWord expWord;
    logic    expValid;
    expKind = kindIdle;
    expWord = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      if (curGrant[p])
      begin
        expKind = kind[p];
        expWord = word[p];
      end
    end
    expValid = (curGrant != '0) && (expKind != kindIdle);
    @(posedge clk);
    #1;
    checkGrant(exp);
    checkValid(expValid);
    if (curGrant != '0)
      checkFlit(expKind, expWord);
    curGrant = exp;
  endtask

  task automatic waitIdle();
    int n;
    driveBodies('0);
    n = 0;
    do
    begin
      @(posedge clk);
      #1;
      n++;
    end while (grant !== '0 && n < 200);
    if (grant !== '0)
    begin
      errors++;
      $display("Timed out after 200 cycles waiting for the output to go idle");
    end
    curGrant = '0;
  endtask

  // Owner was just granted with length len and keeps requesting while others join
  task automatic holdCheck(input int owner, input int len, input logic [numPorts-1:0] others);
    logic [numPorts-1:0] reqs;
    reqs = others | oneHot(owner);
    for (int c = 0; c < len; c++)
    begin
      driveBodies(reqs);
      step(oneHot(owner));
    end
    driveBodies(reqs);
    step(rotationWinner(reqs, owner));
  endtask

  task automatic afterReset();
    repeat (3)
      step('0);
  endtask

  task automatic idlePriority();
    driveBodies(oneHot(portNorth) | oneHot(portWest) | oneHot(portSouth));
    step(oneHot(portNorth));
    waitIdle();
    driveBodies(oneHot(portEast) | oneHot(portSouth));
    step(oneHot(portEast));
    waitIdle();
  endtask

  task automatic holdAndRotate();
    int                  len;
    logic [numPorts-1:0] others;
    for (int round = 0; round < 3; round++)
    begin
      for (int s = 0; s < numPorts; s++)
      begin
        len = $urandom % 7;
        others = 5'($urandom) & ~oneHot(s);
        sendHeader(s, len);
        step(oneHot(s));
        holdCheck(s, len, others);
        waitIdle();
      end
    end
  endtask

  task automatic earlyRelease();
    sendHeader(portEast, 5);
    step(oneHot(portEast));
    driveBodies(oneHot(portEast));
    step(oneHot(portEast));
    // Granted but sending nothing, so the next output is not valid
    kind[portEast] = kindIdle;
    step(oneHot(portEast));
    driveBodies('0);
    step('0);
    sendHeader(portWest, 4);
    step(oneHot(portWest));
    driveBodies(oneHot(portLocal));
    step(oneHot(portLocal));
    waitIdle();
  endtask

  task automatic lateHeader();
    int newLen;
    newLen = ($urandom % 6) + 1;
    // North starts from a zero length that only the header sent under the Local grant can raise
    sendHeader(portNorth, 0);
    req[portNorth] = 1'b0;
    step('0);
    driveBodies('0);
    sendHeader(portLocal, 2);
    step(oneHot(portLocal));
    driveBodies(oneHot(portLocal));
    sendHeader(portNorth, newLen);
    req[portNorth] = 1'b0;
    step(oneHot(portLocal));
    driveBodies(oneHot(portLocal));
    step(oneHot(portLocal));
    waitIdle();
    driveBodies(oneHot(portNorth) | oneHot(portSouth));
    step(oneHot(portNorth));
    holdCheck(portNorth, newLen, oneHot(portSouth));
    waitIdle();
  endtask

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    errors = 0;
    checks = 0;
    curGrant = '0;
    driveBodies('0);
    void'($urandom(32'h9656));
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    afterReset();
    idlePriority();
    holdAndRotate();
    earlyRelease();
    lateHeader();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
verilog/routerPkg.sv
verilog/allocBus.sv
verilog/holdTimer.sv
verilog/portArbiter.sv
verilog/flitSwitch.sv
verilog/outputPortTop.sv
verif/outputPortTb.sv

//--- Bender.yml
package:
  name: output_port_alloc

sources:
  - verilog/routerPkg.sv
  - verilog/allocBus.sv
  - verilog/holdTimer.sv
  - verilog/portArbiter.sv
  - verilog/flitSwitch.sv
  - verilog/outputPortTop.sv
  - target: simulation
    files:
      - verif/outputPortTb.sv
